/* hw/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

    // Register number in bits 7:3, select in bits 2:0
    typedef enum logic [7:0] {
        CP0_BADVADDR = 8'h40,
        CP0_COUNT    = 8'h48,
        CP0_COMPARE  = 8'h58,
        CP0_STATUS   = 8'h60,
        CP0_CAUSE    = 8'h68,
        CP0_EPC      = 8'h70,
        CP0_PRID     = 8'h78,
        CP0_EBASE    = 8'h79,
        CP0_CONFIG   = 8'h80
    } cp0_addr_e;

    // Exception requests as issued by the pipeline
    typedef enum logic [4:0] {
        KIND_NONE    = 5'h00,
        KIND_INT     = 5'h01,
        KIND_ADEL    = 5'h04,
        KIND_ADES    = 5'h05,
        KIND_SYSCALL = 5'h08,
        KIND_BREAK   = 5'h09,
        KIND_RI      = 5'h0a,
        KIND_OV      = 5'h0c,
        KIND_TRAP    = 5'h0d,
        KIND_ERET    = 5'h0e,
        KIND_ADEF    = 5'h0f
    } except_kind_e;

    // Cause.ExcCode values
    typedef enum logic [4:0] {
        CODE_INT  = 5'd0,
        CODE_ADEL = 5'd4,
        CODE_ADES = 5'd5,
        CODE_SYS  = 5'd8,
        CODE_BP   = 5'd9,
        CODE_RI   = 5'd10,
        CODE_OV   = 5'd12,
        CODE_TR   = 5'd13
    } exc_code_e;

    // Move-to and move-from port
    typedef struct packed {
        logic        we;
        logic [7:0]  waddr;
        logic [7:0]  raddr;
        logic [31:0] wdata;
    } cp0_access_t;

    typedef struct packed {
        except_kind_e kind;
        logic [31:0]  pc;
        logic         in_delayslot;
        logic [31:0]  mem_addr;
    } except_req_t;

    // Status fields
    localparam logic [4:0] STATUS_CU0   = 5'd28;
    localparam logic [4:0] STATUS_BEV   = 5'd22;
    localparam logic [4:0] STATUS_IM_HI = 5'd15;
    localparam logic [4:0] STATUS_IM_LO = 5'd8;
    localparam logic [4:0] STATUS_UM    = 5'd4;
    localparam logic [4:0] STATUS_ERL   = 5'd2;
    localparam logic [4:0] STATUS_EXL   = 5'd1;
    localparam logic [4:0] STATUS_IE    = 5'd0;

    // Cause fields
    localparam logic [4:0] CAUSE_BD     = 5'd31;
    localparam logic [4:0] CAUSE_TI     = 5'd30;
    localparam logic [4:0] CAUSE_IV     = 5'd23;
    localparam logic [4:0] CAUSE_WP     = 5'd22;
    localparam logic [4:0] CAUSE_IP_HI  = 5'd15;
    localparam logic [4:0] CAUSE_IP_LO  = 5'd8;
    localparam logic [4:0] CAUSE_EXC_HI = 5'd6;
    localparam logic [4:0] CAUSE_EXC_LO = 5'd2;

    // Software-writable bits
    localparam logic [31:0] STATUS_WMASK = 32'h1040FF17;
    localparam logic [31:0] CAUSE_WMASK  = 32'h00C00300;
    localparam logic [31:0] EBASE_WMASK  = 32'h3FFFF000;
    localparam logic [31:0] CONFIG_WMASK = 32'h00000007;

    // CU0, BEV and ERL set out of reset
    localparam logic [31:0] STATUS_RESET = 32'h10400004;
    // No MMU, kseg0 cacheable
    localparam logic [31:0] CONFIG_RESET = 32'h00000003;
    localparam logic [31:0] EBASE_RESET  = 32'h80000000;
    localparam logic [31:0] PRID_VALUE   = 32'h00018000;

    localparam logic [31:0] BEV_BASE         = 32'hBFC00200;
    localparam logic [31:0] GENERAL_OFFSET   = 32'h00000180;
    localparam logic [31:0] INTERRUPT_OFFSET = 32'h00000200;

endpackage

`default_nettype wire

/* hw/cp0_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0_timer import cp0_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cp0_access_t access_i,
    output logic [31:0] count_o,
    output logic [31:0] compare_o,
    output logic        timer_pending_o
);

    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic        pending_q;
    logic        count_we;
    logic        compare_we;

    assign count_we   = access_i.we && (access_i.waddr == CP0_COUNT);
    assign compare_we = access_i.we && (access_i.waddr == CP0_COMPARE);

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q   <= '0;
            compare_q <= '0;
            pending_q <= 1'b0;
        end else begin
            if (count_we) begin
                count_q <= access_i.wdata;
            end else begin
                count_q <= count_q + 32'd1;
            end

            // Compare write acknowledges the interrupt
            if (compare_we) begin
                compare_q <= access_i.wdata;
                pending_q <= 1'b0;
            end else if (compare_q != '0 && count_q == compare_q) begin
                pending_q <= 1'b1;
            end
        end
    end

    assign count_o         = count_q;
    assign compare_o       = compare_q;
    assign timer_pending_o = pending_q;

    // A zero Compare disables the timer
    assert property (@(posedge clk) disable iff (rst)
        (compare_q == '0 && !pending_q) |=> !pending_q)
        else $error("timer interrupt raised with Compare zero");

endmodule

`default_nettype wire

/* hw/cp0_status_cause.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0_status_cause import cp0_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [5:0]  int_i,
    input  cp0_access_t access_i,
    input  except_req_t except_i,
    input  logic        timer_pending_i,
    output logic [31:0] status_o,
    output logic [31:0] cause_o,
    output logic [31:0] epc_o,
    output logic [31:0] badvaddr_o,
    output logic        user_mode_o
);

    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;
    logic        is_entry;
    exc_code_e   entry_code;

    // Map request kind to ExcCode, eret and none are not entries
    always_comb begin
        is_entry   = 1'b1;
        entry_code = CODE_INT;
        case (except_i.kind)
            KIND_INT:             entry_code = CODE_INT;
            KIND_ADEL, KIND_ADEF: entry_code = CODE_ADEL;
            KIND_ADES:            entry_code = CODE_ADES;
            KIND_SYSCALL:         entry_code = CODE_SYS;
            KIND_BREAK:           entry_code = CODE_BP;
            KIND_RI:              entry_code = CODE_RI;
            KIND_OV:              entry_code = CODE_OV;
            KIND_TRAP:            entry_code = CODE_TR;
            default:              is_entry   = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status_q   <= STATUS_RESET;
            cause_q    <= '0;
            epc_q      <= '0;
            badvaddr_q <= '0;
        end else begin
            if (access_i.we) begin
                case (access_i.waddr)
                    CP0_STATUS: begin
                        status_q <= (status_q & ~STATUS_WMASK) |
                                    (access_i.wdata & STATUS_WMASK);
                    end
                    CP0_CAUSE: begin
                        cause_q <= (cause_q & ~CAUSE_WMASK) |
                                   (access_i.wdata & CAUSE_WMASK);
                    end
                    CP0_EPC: begin
                        epc_q <= access_i.wdata;
                    end
                    default: begin
                    end
                endcase
            end

            // Later assignments override the move-to above
            if (is_entry) begin
                // Nested exception keeps the original return address
                if (!status_q[STATUS_EXL]) begin
                    epc_q             <= except_i.in_delayslot ? except_i.pc - 32'd4
                                                               : except_i.pc;
                    cause_q[CAUSE_BD] <= except_i.in_delayslot;
                end
                status_q[STATUS_EXL] <= 1'b1;
                cause_q[CAUSE_EXC_HI:CAUSE_EXC_LO] <= entry_code;

                if (except_i.kind == KIND_ADEL || except_i.kind == KIND_ADES) begin
                    badvaddr_q <= except_i.mem_addr;
                end else if (except_i.kind == KIND_ADEF) begin
                    badvaddr_q <= except_i.pc;
                end
            end else if (except_i.kind == KIND_ERET) begin
                status_q[STATUS_EXL] <= 1'b0;
            end

            // Hardware interrupt lines land in IP7..IP2
            cause_q[CAUSE_IP_HI:CAUSE_IP_LO + 5'd2] <= int_i;
        end
    end

    // TI lives in the timer block
    always_comb begin
        cause_o           = cause_q;
        cause_o[CAUSE_TI] = timer_pending_i;
    end

    assign status_o   = status_q;
    assign epc_o      = epc_q;
    assign badvaddr_o = badvaddr_q;

    // KSU bit 3 is read-only zero, so UM alone selects user mode
    assign user_mode_o = status_q[STATUS_UM] & ~status_q[STATUS_EXL] &
                         ~status_q[STATUS_ERL];

    assert property (@(posedge clk) disable iff (rst)
        is_entry |=> status_q[STATUS_EXL])
        else $error("EXL not set after exception entry");

    assert property (@(posedge clk) disable iff (rst)
        cause_q[CAUSE_EXC_HI:CAUSE_EXC_LO] inside {CODE_INT, CODE_ADEL, CODE_ADES,
            CODE_SYS, CODE_BP, CODE_RI, CODE_OV, CODE_TR})
        else $error("ExcCode holds an unsupported value");

endmodule

`default_nettype wire

/* hw/cp0_vector_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0_vector_unit import cp0_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cp0_access_t access_i,
    input  except_req_t except_i,
    input  logic [31:0] status_i,
    input  logic [31:0] cause_i,
    input  logic [31:0] epc_i,
    output logic [31:0] ebase_o,
    output logic [31:0] exception_vector_o
);

    logic [31:0] ebase_q;
    logic [31:0] vec_base;
    logic [31:0] vec_offset;

    // Bits 31:30 stay at 2'b10, CPUNum stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            ebase_q <= EBASE_RESET;
        end else if (access_i.we && access_i.waddr == CP0_EBASE) begin
            ebase_q <= (ebase_q & ~EBASE_WMASK) | (access_i.wdata & EBASE_WMASK);
        end
    end

    always_comb begin
        vec_base   = status_i[STATUS_BEV] ? BEV_BASE : {ebase_q[31:12], 12'h000};
        vec_offset = GENERAL_OFFSET;
        if (except_i.kind == KIND_INT && cause_i[CAUSE_IV]) begin
            vec_offset = INTERRUPT_OFFSET;
        end

        // Eret returns to the saved PC
        if (except_i.kind == KIND_ERET) begin
            exception_vector_o = epc_i;
        end else begin
            exception_vector_o = vec_base + vec_offset;
        end
    end

    assign ebase_o = ebase_q;

endmodule

`default_nettype wire

/* hw/cp0_read_port.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0_read_port import cp0_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cp0_access_t access_i,
    input  logic [31:0] count_i,
    input  logic [31:0] compare_i,
    input  logic [31:0] status_i,
    input  logic [31:0] cause_i,
    input  logic [31:0] epc_i,
    input  logic [31:0] badvaddr_i,
    input  logic [31:0] ebase_i,
    output logic [31:0] rdata_o
);

    logic [31:0] config_q;

    // Only K0 is writable, MT reads zero without an MMU
    always_ff @(posedge clk) begin
        if (rst) begin
            config_q <= CONFIG_RESET;
        end else if (access_i.we && access_i.waddr == CP0_CONFIG) begin
            config_q <= (config_q & ~CONFIG_WMASK) | (access_i.wdata & CONFIG_WMASK);
        end
    end

    always_comb begin
        rdata_o = '0;
        if (!rst) begin
            unique case (cp0_addr_e'(access_i.raddr))
                CP0_BADVADDR: rdata_o = badvaddr_i;
                CP0_COUNT:    rdata_o = count_i;
                CP0_COMPARE:  rdata_o = compare_i;
                CP0_STATUS:   rdata_o = status_i;
                CP0_CAUSE:    rdata_o = cause_i;
                CP0_EPC:      rdata_o = epc_i;
                CP0_PRID:     rdata_o = PRID_VALUE;
                CP0_EBASE:    rdata_o = ebase_i;
                CP0_CONFIG:   rdata_o = config_q;
                default:      rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/cp0_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0_regs import cp0_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [5:0]  int_i,
    input  cp0_access_t access_i,
    input  except_req_t except_i,
    output logic [31:0] rdata_o,
    output logic [31:0] status_o,
    output logic [31:0] cause_o,
    output logic [31:0] epc_o,
    output logic [31:0] exception_vector_o,
    output logic        user_mode_o,
    output logic        timer_int_o
);

    logic [31:0] count;
    logic [31:0] compare;
    logic [31:0] badvaddr;
    logic [31:0] ebase;

    cp0_timer i_cp0_timer (
        .clk             (clk),
        .rst             (rst),
        .access_i        (access_i),
        .count_o         (count),
        .compare_o       (compare),
        .timer_pending_o (timer_int_o)
    );

    cp0_status_cause i_cp0_status_cause (
        .clk             (clk),
        .rst             (rst),
        .int_i           (int_i),
        .access_i        (access_i),
        .except_i        (except_i),
        .timer_pending_i (timer_int_o),
        .status_o        (status_o),
        .cause_o         (cause_o),
        .epc_o           (epc_o),
        .badvaddr_o      (badvaddr),
        .user_mode_o     (user_mode_o)
    );

    cp0_vector_unit i_cp0_vector_unit (
        .clk                (clk),
        .rst                (rst),
        .access_i           (access_i),
        .except_i           (except_i),
        .status_i           (status_o),
        .cause_i            (cause_o),
        .epc_i              (epc_o),
        .ebase_o            (ebase),
        .exception_vector_o (exception_vector_o)
    );

    cp0_read_port i_cp0_read_port (
        .clk        (clk),
        .rst        (rst),
        .access_i   (access_i),
        .count_i    (count),
        .compare_i  (compare),
        .status_i   (status_o),
        .cause_i    (cause_o),
        .epc_i      (epc_o),
        .badvaddr_i (badvaddr),
        .ebase_i    (ebase),
        .rdata_o    (rdata_o)
    );

endmodule

`default_nettype wire

/* testbench/tb_cp0_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cp0_regs import cp0_pkg::*; ();

    localparam int WATCHDOG_CYCLES = 2000;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [5:0]  int_lines = '0;
    logic        wr_en = 1'b0;
    logic [7:0]  wr_addr = '0;
    logic [7:0]  rd_addr = '0;
    logic [31:0] wr_data = '0;
    except_req_t exc = '{kind: KIND_NONE, pc: '0, in_delayslot: 1'b0, mem_addr: '0};
    cp0_access_t access;
    int          rd_idx = 0;
    int          assert_errors = 0;
    int          other_errors = 0;

    logic [31:0] rdata_o, status_o, cause_o, epc_o, exception_vector_o;
    logic        user_mode_o, timer_int_o;

    // Expected state
    logic [31:0] exp_status, exp_cause, exp_epc, exp_badvaddr;
    logic [31:0] exp_ebase, exp_config, exp_count, exp_compare;
    logic        exp_ti;
    logic [31:0] exp_cause_full, exp_vector, exp_rdata;
    logic        exp_user;

    // Two addresses outside the map read as zero
    logic [7:0] read_addrs [11] = '{CP0_BADVADDR, CP0_COUNT, CP0_COMPARE, CP0_STATUS,
        CP0_CAUSE, CP0_EPC, CP0_PRID, CP0_EBASE, CP0_CONFIG, 8'h00, 8'hF8};

    assign access = '{we: wr_en, waddr: wr_addr, raddr: rd_addr, wdata: wr_data};

    cp0_regs i_cp0_regs (
        .clk                (clk),
        .rst                (rst),
        .int_i              (int_lines),
        .access_i           (access),
        .except_i           (exc),
        .rdata_o            (rdata_o),
        .status_o           (status_o),
        .cause_o            (cause_o),
        .epc_o              (epc_o),
        .exception_vector_o (exception_vector_o),
        .user_mode_o        (user_mode_o),
        .timer_int_o        (timer_int_o)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] merge_masked(input logic [31:0] old_val,
                                                 input logic [31:0] new_val,
                                                 input logic [31:0] mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    function automatic logic [4:0] code_for(input except_kind_e k);
        case (k)
            KIND_ADEL, KIND_ADEF: return 5'd4;
            KIND_ADES:            return 5'd5;
            KIND_SYSCALL:         return 5'd8;
            KIND_BREAK:           return 5'd9;
            KIND_RI:              return 5'd10;
            KIND_OV:              return 5'd12;
            KIND_TRAP:            return 5'd13;
            default:              return 5'd0;
        endcase
    endfunction

    function automatic logic [31:0] expected_read(input logic [7:0] addr);
        case (addr)
            CP0_BADVADDR: return exp_badvaddr;
            CP0_COUNT:    return exp_count;
            CP0_COMPARE:  return exp_compare;
            CP0_STATUS:   return exp_status;
            CP0_CAUSE:    return exp_cause_full;
            CP0_EPC:      return exp_epc;
            CP0_PRID:     return 32'h00018000;
            CP0_EBASE:    return exp_ebase;
            CP0_CONFIG:   return exp_config;
            default:      return 32'h0;
        endcase
    endfunction

    always @(posedge clk) begin : ref_model
        logic [31:0] st, ca, ep, bv;
        logic        entry;
        if (rst) begin
            exp_status   <= 32'h10400004;
            exp_cause    <= '0;
            exp_epc      <= '0;
            exp_badvaddr <= '0;
            exp_ebase    <= 32'h80000000;
            exp_config   <= 32'h00000003;
            exp_count    <= '0;
            exp_compare  <= '0;
            exp_ti       <= 1'b0;
        end else begin
            st = exp_status;
            ca = exp_cause;
            ep = exp_epc;
            bv = exp_badvaddr;
            entry = exc.kind != KIND_NONE && exc.kind != KIND_ERET;
            if (access.we) begin
                case (access.waddr)
                    CP0_STATUS: st = merge_masked(st, access.wdata, STATUS_WMASK);
                    CP0_CAUSE:  ca = merge_masked(ca, access.wdata, CAUSE_WMASK);
                    CP0_EPC:    ep = access.wdata;
                    CP0_EBASE:  exp_ebase <= merge_masked(exp_ebase, access.wdata, EBASE_WMASK);
                    CP0_CONFIG: exp_config <= merge_masked(exp_config, access.wdata, CONFIG_WMASK);
                    default: begin
                    end
                endcase
            end
            // Exception fields take priority over the move-to
            if (entry) begin
                if (!exp_status[STATUS_EXL]) begin
                    ep = exc.in_delayslot ? exc.pc - 32'd4 : exc.pc;
                    ca[CAUSE_BD] = exc.in_delayslot;
                end
                st[STATUS_EXL] = 1'b1;
                ca[6:2] = code_for(exc.kind);
                if (exc.kind == KIND_ADEL || exc.kind == KIND_ADES) begin
                    bv = exc.mem_addr;
                end else if (exc.kind == KIND_ADEF) begin
                    bv = exc.pc;
                end
            end else if (exc.kind == KIND_ERET) begin
                st[STATUS_EXL] = 1'b0;
            end
            ca[15:10] = int_lines;
            exp_status   <= st;
            exp_cause    <= ca;
            exp_epc      <= ep;
            exp_badvaddr <= bv;

            if (access.we && access.waddr == CP0_COMPARE) begin
                exp_compare <= access.wdata;
                exp_ti      <= 1'b0;
            end else if (exp_compare != 32'h0 && exp_count == exp_compare) begin
                exp_ti <= 1'b1;
            end
            exp_count <= (access.we && access.waddr == CP0_COUNT) ? access.wdata
                                                                  : exp_count + 32'd1;
        end
    end

    always_comb begin
        exp_cause_full = {exp_cause[31], exp_ti, exp_cause[29:0]};
        exp_rdata = expected_read(rd_addr);
        exp_user = exp_status[4] & ~exp_status[1] & ~exp_status[2];
        if (exc.kind == KIND_ERET) begin
            exp_vector = exp_epc;
        end else begin
            exp_vector = (exp_status[22] ? 32'hBFC00200 : {exp_ebase[31:12], 12'h000}) +
                ((exc.kind == KIND_INT && exp_cause[23]) ? 32'h200 : 32'h180);
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        assert_errors++;
        $display("error: %s got %h expected %h", name, got, expected);
    endtask

    rst_read_zero: assert property (@(posedge clk) rst |-> rdata_o == 32'h0)
        else report_mismatch("rdata_o", rdata_o, 32'h0);
    rdata_ok: assert property (@(posedge clk) disable iff (rst) rdata_o == exp_rdata)
        else report_mismatch("rdata_o", rdata_o, exp_rdata);
    status_ok: assert property (@(posedge clk) disable iff (rst) status_o == exp_status)
        else report_mismatch("status_o", status_o, exp_status);
    cause_ok: assert property (@(posedge clk) disable iff (rst) cause_o == exp_cause_full)
        else report_mismatch("cause_o", cause_o, exp_cause_full);
    epc_ok: assert property (@(posedge clk) disable iff (rst) epc_o == exp_epc)
        else report_mismatch("epc_o", epc_o, exp_epc);
    vector_ok: assert property (@(posedge clk) disable iff (rst)
        exception_vector_o == exp_vector)
        else report_mismatch("exception_vector_o", exception_vector_o, exp_vector);
    user_ok: assert property (@(posedge clk) disable iff (rst) user_mode_o == exp_user)
        else report_mismatch("user_mode_o", {31'b0, user_mode_o}, {31'b0, exp_user});
    timer_ok: assert property (@(posedge clk) disable iff (rst) timer_int_o == exp_ti)
        else report_mismatch("timer_int_o", {31'b0, timer_int_o}, {31'b0, exp_ti});
    timer_off_at_zero: assert property (@(posedge clk) disable iff (rst)
        (exp_compare == 32'h0 && !timer_int_o) |=> !timer_int_o)
        else report_mismatch("timer_int_o", {31'b0, timer_int_o}, 32'h0);
    ip_delay_ok: assert property (@(posedge clk) disable iff (rst)
        !rst |=> cause_o[15:10] == $past(int_lines))
        else report_mismatch("cause_o[15:10]", {26'b0, cause_o[15:10]},
                             {26'b0, $past(int_lines)});
    eret_vector_ok: assert property (@(posedge clk) disable iff (rst)
        exc.kind == KIND_ERET |-> exception_vector_o == epc_o)
        else report_mismatch("exception_vector_o", exception_vector_o, epc_o);
    eret_clears_exl: assert property (@(posedge clk) disable iff (rst)
        exc.kind == KIND_ERET |=> !status_o[1])
        else report_mismatch("status_o", status_o, status_o & ~32'h2);

    // Interrupt lines and read address change every cycle
    always @(posedge clk) begin : drive_background
        logic [31:0] r;
        r = $urandom();
        int_lines <= r[5:0];
        rd_addr   <= read_addrs[rd_idx];
        rd_idx    <= (rd_idx == 10) ? 0 : rd_idx + 1;
    end

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic raise_exception(input except_kind_e k, input logic dslot);
        logic [31:0] pc_val;
        logic [31:0] addr_val;
        pc_val = $urandom();
        addr_val = $urandom();
        exc <= '{kind: k, pc: pc_val, in_delayslot: dslot, mem_addr: addr_val};
        @(posedge clk);
        exc.kind <= KIND_NONE;
    endtask

    task automatic masked_write_pass();
        for (int round = 0; round < 3; round++) begin
            for (int i = 0; i < 11; i++) begin
                write_reg(read_addrs[i], $urandom());
            end
        end
        idle(12);
    endtask

    task automatic timer_pass();
        int          delta;
        int          n;
        logic [31:0] c;
        for (int round = 0; round < 3; round++) begin
            delta = $urandom_range(4, 12);
            @(negedge clk);
            c = exp_count;
            @(posedge clk);
            write_reg(CP0_COMPARE, c + delta);
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!timer_int_o && n < delta + 2);
            if (!timer_int_o) begin
                other_errors++;
                $display("Timer interrupt did not rise within %0d cycles", delta + 2);
            end
            @(posedge clk);
            idle(3);
            write_reg(CP0_COMPARE, 32'h0);
        end
        // Count wraps through zero while Compare is zero
        write_reg(CP0_COUNT, 32'hFFFFFFF8);
        idle(16);
    endtask

    task automatic exception_pass();
        except_kind_e kinds [9] = '{KIND_INT, KIND_ADEL, KIND_ADES, KIND_SYSCALL,
            KIND_BREAK, KIND_RI, KIND_OV, KIND_TRAP, KIND_ADEF};
        for (int i = 0; i < 9; i++) begin
            raise_exception(KIND_ERET, 1'b0);
            raise_exception(kinds[i], i[0]);
            // Nested entry keeps EPC
            raise_exception(kinds[i], 1'b1);
            idle(12);
        end
    endtask

    task automatic vector_pass();
        write_reg(CP0_STATUS, 32'h0);
        write_reg(CP0_EBASE, $urandom());
        raise_exception(KIND_SYSCALL, 1'b0);
        write_reg(CP0_CAUSE, 32'h00800000);
        raise_exception(KIND_INT, 1'b0);
        raise_exception(KIND_ERET, 1'b0);
        idle(2);
    endtask

    task automatic mode_pass();
        write_reg(CP0_STATUS, 32'h10);
        idle(2);
        write_reg(CP0_STATUS, 32'h14);
        write_reg(CP0_STATUS, 32'h10);
        raise_exception(KIND_SYSCALL, 1'b0);
        raise_exception(KIND_ERET, 1'b0);
        idle(2);
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog timeout, run exceeded %0d clock cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin : main
        void'($urandom(32'h6700));
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        idle(12);
        masked_write_pass();
        timer_pass();
        vector_pass();
        exception_pass();
        mode_pass();
        $display("Errors: %0d check mismatches, %0d other failures",
                 assert_errors, other_errors);
        if (assert_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hw/cp0_pkg.sv
hw/cp0_timer.sv
hw/cp0_status_cause.sv
hw/cp0_vector_unit.sv
hw/cp0_read_port.sv
hw/cp0_regs.sv
testbench/tb_cp0_regs.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
        --top-module tb_cp0_regs -f tb.f -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_cp0_regs)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1
